/* Makefile */
# Verilator build and run for the acquisition store

TOOL      = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = acqStorageTb
FILELIST  = acqStorage.f
BUILD     = obj_dir
LOG       = sim.log
PASS_TEXT = Test passed

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

# The log decides the result, not the simulator exit status
run: compile
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^$(PASS_TEXT)$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* acqStorage.f */
logic/acqPkg.sv
logic/eventAccumulator.sv
logic/recordFifo.sv
logic/byteSerializer.sv
logic/acqStorageTop.sv
dv/acqStorage_assertions.sv
dv/acqStorageChecker.sv
dv/acqStorageTb.sv

/* dv/acqStorageChecker.sv */
`timescale 1ns/1ps
`default_nettype none

module acqStorageChecker import acqPkg::*; (
    input  wire             ReadClock,
    input  wire             rst,
    input  wire sampleWordT DataIn,
    input  wire             FastTrigger,
    input  wire             ReadEnable,
    input  wire byteT       DataOut,
    input  wire             DataReady,
    input  wire eventCountT numEvents,
    input  wire lengthT     dataLength,
    input  wire [8*12-1:0]  testName,
    output int              errorCount,
    output int              frameCount,
    output int              byteCount
);

    // Reference totals in DQD, DID, DQ, DI order
    sumT    sums [MaxLength][NumChannels];
    byteT   expQ [$];
    logic   capturing;
    logic   justReset;
    logic   footerTaken;
    lengthT capIdx;
    lengthT lenHeld;
    int     eventCnt;
    int     eventsHeld;
    int     frameBytes;

    initial begin
        errorCount  = 0;
        frameCount  = 0;
        byteCount   = 0;
        capturing   = 1'b0;
        justReset   = 1'b0;
        footerTaken = 1'b0;
        capIdx      = '0;
        lenHeld     = '0;
        eventCnt    = 0;
        eventsHeld  = 0;
        frameBytes  = 0;
    end

    function automatic sumT addSample(sumT total, sampleT sample, logic first);
        if (first) begin
            return sumT'(sample);
        end
        return total + sumT'(sample);
    endfunction

    task automatic pushSum(input sumT total);
        expQ.push_back(total[15:8]);
        expQ.push_back(total[7:0]);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Expected frame
    ////////////////////////////////////////////////////////////////////////////

    task automatic buildFrame();
        lengthT idx;
        expQ.push_back(8'h80);
        expQ.push_back(8'h02);
        for (int i = 0; i < int'(lenHeld); i++) begin
            idx = lengthT'(i);
            pushSum(sums[idx][0]);
            pushSum(sums[idx][1]);
            pushSum(sums[idx][2]);
            pushSum(sums[idx][3]);
        end
        expQ.push_back(8'h80);
        expQ.push_back(8'h01);
    endtask

    // Triggers are ignored while a frame is still owed
    task automatic sampleStep();
        logic first;
        if (!capturing && FastTrigger && expQ.size() == 0) begin
            capturing = 1'b1;
            capIdx    = '0;
            if (eventCnt == 0) begin
                lenHeld    = dataLength;
                eventsHeld = int'(numEvents);
            end
        end
        if (capturing) begin
            first = (eventCnt == 0);
            sums[capIdx][0] = addSample(sums[capIdx][0], DataIn.dqd, first);
            sums[capIdx][1] = addSample(sums[capIdx][1], DataIn.did, first);
            sums[capIdx][2] = addSample(sums[capIdx][2], DataIn.dq, first);
            sums[capIdx][3] = addSample(sums[capIdx][3], DataIn.di, first);
            if (int'(capIdx) == int'(lenHeld) - 1) begin
                capturing = 1'b0;
                eventCnt++;
                if (eventCnt >= eventsHeld) begin
                    buildFrame();
                    eventCnt = 0;
                end
            end else begin
                capIdx = capIdx + 1'b1;
            end
        end
    endtask

    task automatic readStep();
        byteT expected;
        if (ReadEnable && DataReady) begin
            byteCount++;
            if (expQ.size() == 0) begin
                $display("A byte was read while no frame was expected in test %s", testName);
                errorCount++;
            end else begin
                expected = expQ.pop_front();
                if (DataOut !== expected) begin
                    $display("error: test %s byte %0d expected 0x%h actual 0x%h",
                             testName, frameBytes, expected, DataOut);
                    errorCount++;
                end
                frameBytes++;
                if (expQ.size() == 0) begin
                    frameCount++;
                    frameBytes  = 0;
                    footerTaken = 1'b1;
                end
            end
        end
    endtask

    always @(posedge ReadClock) begin
        if (rst) begin
            expQ.delete();
            capturing   = 1'b0;
            eventCnt    = 0;
            frameBytes  = 0;
            footerTaken = 1'b0;
            justReset   = 1'b1;
        end else begin
            if (justReset && DataReady) begin
                $display("error: test %s DataReady after reset expected 0 actual 1",
                         testName);
                errorCount++;
            end
            justReset = 1'b0;
            // Frame ends at the footer, no further byte may be offered
            if (footerTaken && DataReady) begin
                $display("error: test %s DataReady after footer expected 0 actual 1",
                         testName);
                errorCount++;
            end
            footerTaken = 1'b0;
            sampleStep();
            readStep();
        end
    end

endmodule

`default_nettype wire

/* dv/acqStorageTb.sv */
`timescale 1ns/1ps
`default_nettype none

module acqStorageTb import acqPkg::*; ();

    // One row per block of triggers
    typedef struct packed {
        logic [8*12-1:0] name;
        eventCountT      events;
        lengthT          length;
        byteT            readGap;
        logic            resetMid;
    } testRowT;

    logic            ReadClock;
    logic            rst;
    sampleWordT      DataIn;
    logic            FastTrigger;
    logic            ReadEnable;
    eventCountT      numEvents;
    lengthT          dataLength;
    byteT            DataOut;
    logic            DataReady;

    logic [8*12-1:0] curName;
    int              seed = 39757;
    int              errorCount;
    int              frameCount;
    int              byteCount;
    int              timeoutCount;
    logic            aborted;
    testRowT         testTable [7];

    acqStorageTop u_acqStorageTop (
        .DataIn      (DataIn),
        .FastTrigger (FastTrigger),
        .ReadEnable  (ReadEnable),
        .ReadClock   (ReadClock),
        .rst         (rst),
        .numEvents   (numEvents),
        .dataLength  (dataLength),
        .DataOut     (DataOut),
        .DataReady   (DataReady)
    );

    acqStorageChecker u_acqStorageChecker (
        .ReadClock   (ReadClock),
        .rst         (rst),
        .DataIn      (DataIn),
        .FastTrigger (FastTrigger),
        .ReadEnable  (ReadEnable),
        .DataOut     (DataOut),
        .DataReady   (DataReady),
        .numEvents   (numEvents),
        .dataLength  (dataLength),
        .testName    (curName),
        .errorCount  (errorCount),
        .frameCount  (frameCount),
        .byteCount   (byteCount)
    );

    always begin
        #50;
        ReadClock = ~ReadClock;
    end

    // Fresh sample word every cycle
    always @(posedge ReadClock) begin
        #1;
        DataIn = sampleWordT'($random(seed));
    end

    ////////////////////////////////////////////////////////////////////////////
    // Host side tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic nextCycle();
        @(posedge ReadClock);
        #1;
    endtask

    task automatic applyReset();
        rst = 1'b1;
        repeat (5) nextCycle();
        rst = 1'b0;
    endtask

    // Trigger seen on the next edge takes index 0
    task automatic fireTrigger(input lengthT len);
        FastTrigger = 1'b1;
        nextCycle();
        FastTrigger = 1'b0;
        repeat (int'(len) - 1) nextCycle();
        repeat (2) nextCycle();
    endtask

    task automatic readByte(input int gap);
        int waited;
        int readyLimit;
        waited     = 0;
        readyLimit = 4000;
        while (!DataReady && waited < readyLimit) begin
            nextCycle();
            waited++;
        end
        if (!DataReady) begin
            $display("Timeout: no byte became ready in test %s", curName);
            timeoutCount++;
            aborted = 1'b1;
        end else begin
            repeat (gap) nextCycle();
            ReadEnable = 1'b1;
            nextCycle();
            ReadEnable = 1'b0;
        end
    endtask

    // Read until the checker sees the footer
    task automatic readFrame(input testRowT row);
        int startFrames;
        int reads;
        int readLimit;
        startFrames = frameCount;
        reads       = 0;
        readLimit   = 4 + 8 * int'(row.length) + 16;
        while (frameCount == startFrames && reads < readLimit && !aborted) begin
            readByte(int'(row.readGap));
            reads++;
        end
        if (!aborted && frameCount == startFrames) begin
            $display("Timeout: the frame of test %s did not complete", curName);
            timeoutCount++;
            aborted = 1'b1;
        end
    endtask

    task automatic runRow(input testRowT row);
        curName    = row.name;
        numEvents  = row.events;
        dataLength = row.length;
        nextCycle();
        for (int ev = 0; ev < int'(row.events); ev++) begin
            fireTrigger(row.length);
        end
        if (row.resetMid) begin
            // Cut the frame short, the next row checks recovery
            for (int k = 0; k < 6 && !aborted; k++) begin
                readByte(int'(row.readGap));
            end
            applyReset();
        end else begin
            readFrame(row);
        end
        repeat (3) nextCycle();
    endtask

    initial begin
        ReadClock    = 1'b0;
        rst          = 1'b1;
        DataIn       = '0;
        FastTrigger  = 1'b0;
        ReadEnable   = 1'b0;
        numEvents    = '0;
        dataLength   = '0;
        curName      = "reset       ";
        timeoutCount = 0;
        aborted      = 1'b0;

        // Name, events, length, read gap, reset mid frame
        testTable[0] = '{"single_short", 8'd1,  7'd4,  8'd0, 1'b0};
        testTable[1] = '{"many_events ", 8'd5,  7'd6,  8'd0, 1'b0};
        testTable[2] = '{"length_one  ", 8'd3,  7'd1,  8'd1, 1'b0};
        testTable[3] = '{"back_press  ", 8'd4,  7'd20, 8'd6, 1'b0};
        testTable[4] = '{"reset_mid   ", 8'd2,  7'd12, 8'd0, 1'b1};
        testTable[5] = '{"after_reset ", 8'd3,  7'd10, 8'd2, 1'b0};
        testTable[6] = '{"long_block  ", 8'd40, 7'd9,  8'd0, 1'b0};

        applyReset();
        for (int r = 0; r < $size(testTable) && !aborted; r++) begin
            runRow(testTable[r]);
        end

        $display("Summary: %0d frames, %0d bytes checked, %0d errors, %0d timeouts",
                 frameCount, byteCount, errorCount, timeoutCount);
        if (errorCount == 0 && timeoutCount == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* dv/acqStorage_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module acqStorageAssertions import acqPkg::*; (
    input wire                   ReadClock,
    input wire                   rst,
    input wire [CreditWidth-1:0] level,
    input wire                   countUp
);

    // Occupancy and credits are both bounded by the buffer depth
    levelInRange: assert property (
        @(posedge ReadClock) disable iff (rst)
        int'(level) <= FifoDepth
    ) else $error("count above the buffer depth");

    // No count may go up once it sits at the buffer depth
    noRaiseAtDepth: assert property (
        @(posedge ReadClock) disable iff (rst)
        countUp |-> (int'(level) < FifoDepth)
    ) else $error("count raised while already at the buffer depth");

endmodule

// A write into a full buffer means the producer wrote with no credit left
bind recordFifo acqStorageAssertions u_fifoChecks (
    .ReadClock (ReadClock),
    .rst       (rst),
    .level     (occupancy),
    .countUp   (recWrite)
);

// Credits come back only for records that were written
bind eventAccumulator acqStorageAssertions u_creditChecks (
    .ReadClock (ReadClock),
    .rst       (rst),
    .level     (credits),
    .countUp   (creditReturn)
);

`default_nettype wire

/* logic/acqPkg.sv */
`default_nettype none

package acqPkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths and counts
    ////////////////////////////////////////////////////////////////////////////

    localparam int SampleWidth = 8;
    localparam int SumWidth    = 16;
    localparam int NumChannels = 4;
    localparam int MaxLength   = 128;
    // Record buffer depth, also the starting credit count
    localparam int FifoDepth   = 8;
    localparam int CreditWidth = 4;

    typedef logic [SampleWidth-1:0] sampleT;
    typedef logic [SumWidth-1:0]    sumT;
    typedef logic [7:0]             eventCountT;
    typedef logic [6:0]             lengthT;
    typedef logic [7:0]             byteT;

    // Same bit order as DataIn, DI in the top byte
    typedef struct packed {
        sampleT di;
        sampleT did;
        sampleT dq;
        sampleT dqd;
    } sampleWordT;

    typedef struct packed {
        sumT  dqd;
        sumT  did;
        sumT  dq;
        sumT  di;
        logic lastSample;
    } accRecordT;

    typedef enum logic [1:0] {AccIdle, AccCapture, AccArmed, AccDrain} accStateT;

    typedef enum logic [2:0] {
        SerIdle,
        SerHeadHi,
        SerHeadLo,
        SerData,
        SerFootHi,
        SerFootLo
    } serStateT;

    // Frame marker bytes
    localparam byteT FrameMark = 8'h80;
    localparam byteT HeaderTag = 8'h02;
    localparam byteT FooterTag = 8'h01;

endpackage

`default_nettype wire

/* logic/acqStorageTop.sv */
`timescale 1ns/1ps
`default_nettype none

module acqStorageTop import acqPkg::*; (
    input  wire sampleWordT DataIn,
    input  wire             FastTrigger,
    input  wire             ReadEnable,
    input  wire             ReadClock,
    input  wire             rst,
    input  wire eventCountT numEvents,
    input  wire lengthT     dataLength,
    output byteT            DataOut,
    output logic            DataReady
);

    // Producer to buffer
    logic      recWrite;
    accRecordT recData;
    logic      creditReturn;

    // Buffer to serializer
    logic      recValid;
    accRecordT recHead;
    logic      recPop;

    eventAccumulator u_eventAccumulator (
        .ReadClock    (ReadClock),
        .rst          (rst),
        .DataIn       (DataIn),
        .FastTrigger  (FastTrigger),
        .numEvents    (numEvents),
        .dataLength   (dataLength),
        .creditReturn (creditReturn),
        .recWrite     (recWrite),
        .recData      (recData)
    );

    recordFifo u_recordFifo (
        .ReadClock    (ReadClock),
        .rst          (rst),
        .recWrite     (recWrite),
        .recData      (recData),
        .recPop       (recPop),
        .recValid     (recValid),
        .recHead      (recHead),
        .creditReturn (creditReturn)
    );

    byteSerializer u_byteSerializer (
        .ReadClock  (ReadClock),
        .rst        (rst),
        .recValid   (recValid),
        .recHead    (recHead),
        .ReadEnable (ReadEnable),
        .recPop     (recPop),
        .DataOut    (DataOut),
        .DataReady  (DataReady)
    );

endmodule

`default_nettype wire

/* logic/byteSerializer.sv */
`timescale 1ns/1ps
`default_nettype none

module byteSerializer import acqPkg::*; (
    input  wire            ReadClock,
    input  wire            rst,
    input  wire            recValid,
    input  wire accRecordT recHead,
    input  wire            ReadEnable,
    output logic           recPop,
    output byteT           DataOut,
    output logic           DataReady
);

    serStateT                              serState;
    logic [$clog2(2*NumChannels)-1:0]      byteIdx;
    logic [$clog2(2*NumChannels)-1:0]      nextIdx;
    logic                                  taken;
    logic                                  lastByte;
    logic                                  loadByte;
    byteT                                  nextByte;

    // Byte order DQD, DID, DQ, DI with the high byte first
    function automatic byteT byteOf(accRecordT rec, logic [$clog2(2*NumChannels)-1:0] idx);
        sumT word;
        case (idx[2:1])
            2'd0:    word = rec.dqd;
            2'd1:    word = rec.did;
            2'd2:    word = rec.dq;
            default: word = rec.di;
        endcase
        return idx[0] ? word[7:0] : word[15:8];
    endfunction

    assign taken    = ReadEnable && DataReady;
    assign nextIdx  = byteIdx + 1'b1;
    assign lastByte = (int'(byteIdx) == 2*NumChannels - 1);
    assign recPop   = (serState == SerData) && taken && lastByte;

    ////////////////////////////////////////////////////////////////////////////
    // Next byte selection
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        loadByte = 1'b0;
        nextByte = FrameMark;
        case (serState)
            SerIdle: begin
                loadByte = recValid;
                nextByte = FrameMark;
            end
            SerHeadHi: begin
                loadByte = taken;
                nextByte = HeaderTag;
            end
            SerHeadLo: begin
                loadByte = taken && recValid;
                nextByte = byteOf(recHead, '0);
            end
            SerData: begin
                if (!DataReady) begin
                    // Waiting on the next record after a pop
                    loadByte = recValid;
                    nextByte = byteOf(recHead, byteIdx);
                end else if (taken && lastByte) begin
                    loadByte = recHead.lastSample;
                    nextByte = FrameMark;
                end else if (taken) begin
                    loadByte = 1'b1;
                    nextByte = byteOf(recHead, nextIdx);
                end
            end
            SerFootHi: begin
                loadByte = taken;
                nextByte = FooterTag;
            end
            default: begin
                loadByte = 1'b0;
                nextByte = FrameMark;
            end
        endcase
    end

    always_ff @(posedge ReadClock) begin
        if (loadByte) begin
            DataOut <= nextByte;
        end
    end

    // Framing FSM
    always_ff @(posedge ReadClock) begin
        if (rst) begin
            serState  <= SerIdle;
            byteIdx   <= '0;
            DataReady <= 1'b0;
        end else begin
            if (loadByte) begin
                DataReady <= 1'b1;
            end else if (taken) begin
                DataReady <= 1'b0;
            end
            case (serState)
                SerIdle:   if (recValid) serState <= SerHeadHi;
                SerHeadHi: if (taken) serState <= SerHeadLo;
                SerHeadLo: begin
                    if (taken) begin
                        byteIdx  <= '0;
                        serState <= SerData;
                    end
                end
                SerData: begin
                    if (taken) begin
                        byteIdx <= nextIdx;
                        if (lastByte && recHead.lastSample) begin
                            serState <= SerFootHi;
                        end
                    end
                end
                SerFootHi: if (taken) serState <= SerFootLo;
                default:   if (taken) serState <= SerIdle;
            endcase
        end
    end

endmodule

`default_nettype wire

/* logic/eventAccumulator.sv */
`timescale 1ns/1ps
`default_nettype none

module eventAccumulator import acqPkg::*; (
    input  wire             ReadClock,
    input  wire             rst,
    input  wire sampleWordT DataIn,
    input  wire             FastTrigger,
    input  wire eventCountT numEvents,
    input  wire lengthT     dataLength,
    input  wire             creditReturn,
    output logic            recWrite,
    output accRecordT       recData
);

    accStateT               accState;
    lengthT                 sampleIdx;
    lengthT                 lenLatched;
    eventCountT             eventCnt;
    eventCountT             eventsLatched;
    logic [CreditWidth-1:0] credits;

    // Channel order in memory is DQD, DID, DQ, DI
    sumT [NumChannels-1:0] sumMem [MaxLength];

    logic                  capEn;
    logic                  capLast;
    lengthT                capIdx;
    lengthT                curLen;
    eventCountT            curEvents;
    eventCountT            nextCnt;
    sumT [NumChannels-1:0] sampleExt;
    sumT [NumChannels-1:0] capSum;

    ////////////////////////////////////////////////////////////////////////////
    // Capture and accumulate
    ////////////////////////////////////////////////////////////////////////////

    assign sampleExt[0] = sumT'(DataIn.dqd);
    assign sampleExt[1] = sumT'(DataIn.did);
    assign sampleExt[2] = sumT'(DataIn.dq);
    assign sampleExt[3] = sumT'(DataIn.di);

    always_comb begin
        capEn = (accState == AccCapture) ||
                (FastTrigger && (accState == AccIdle || accState == AccArmed));
        // Trigger cycle always takes index 0
        capIdx    = (accState == AccCapture) ? sampleIdx : '0;
        // Settings are only taken from the ports at the first trigger
        curLen    = (accState == AccIdle) ? dataLength : lenLatched;
        curEvents = (accState == AccIdle) ? numEvents : eventsLatched;
        capLast   = (capIdx == lengthT'(curLen - 1'b1));
        nextCnt   = eventCountT'(eventCnt + 1'b1);
        for (int ch = 0; ch < NumChannels; ch++) begin
            capSum[ch] = (eventCnt == '0) ? sampleExt[ch] : sumMem[capIdx][ch] + sampleExt[ch];
        end
    end

    always_ff @(posedge ReadClock) begin
        if (capEn) begin
            sumMem[capIdx] <= capSum;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Drain under credit
    ////////////////////////////////////////////////////////////////////////////

    assign recWrite = (accState == AccDrain) && (credits != '0);

    always_comb begin
        recData.dqd        = sumMem[sampleIdx][0];
        recData.did        = sumMem[sampleIdx][1];
        recData.dq         = sumMem[sampleIdx][2];
        recData.di         = sumMem[sampleIdx][3];
        recData.lastSample = (sampleIdx == lengthT'(lenLatched - 1'b1));
    end

    always_ff @(posedge ReadClock) begin
        if (rst) begin
            credits <= CreditWidth'(FifoDepth);
        end else begin
            case ({recWrite, creditReturn})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    // Control FSM
    always_ff @(posedge ReadClock) begin
        if (rst) begin
            accState      <= AccIdle;
            sampleIdx     <= '0;
            eventCnt      <= '0;
            lenLatched    <= '0;
            eventsLatched <= '0;
        end else begin
            case (accState)
                AccIdle, AccCapture, AccArmed: begin
                    if (capEn) begin
                        if (accState == AccIdle) begin
                            lenLatched    <= dataLength;
                            eventsLatched <= numEvents;
                        end
                        if (capLast) begin
                            sampleIdx <= '0;
                            eventCnt  <= nextCnt;
                            accState  <= (nextCnt >= curEvents) ? AccDrain : AccArmed;
                        end else begin
                            sampleIdx <= lengthT'(capIdx + 1'b1);
                            accState  <= AccCapture;
                        end
                    end
                end
                AccDrain: begin
                    if (recWrite) begin
                        if (recData.lastSample) begin
                            sampleIdx <= '0;
                            eventCnt  <= '0;
                            accState  <= AccIdle;
                        end else begin
                            sampleIdx <= lengthT'(sampleIdx + 1'b1);
                        end
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* logic/recordFifo.sv */
`timescale 1ns/1ps
`default_nettype none

module recordFifo import acqPkg::*; (
    input  wire            ReadClock,
    input  wire            rst,
    input  wire            recWrite,
    input  wire accRecordT recData,
    input  wire            recPop,
    output logic           recValid,
    output accRecordT      recHead,
    output logic           creditReturn
);

    accRecordT storage [FifoDepth];

    logic [$clog2(FifoDepth)-1:0] wrPtr;
    logic [$clog2(FifoDepth)-1:0] rdPtr;
    // Holds 0 to FifoDepth, same range as the credits
    logic [CreditWidth-1:0]       occupancy;
    logic                         popNow;

    ////////////////////////////////////////////////////////////////////////////
    // Head of queue
    ////////////////////////////////////////////////////////////////////////////

    assign recValid     = (occupancy != '0);
    assign recHead      = storage[rdPtr];
    assign popNow       = recPop && recValid;
    // One credit back per record removed
    assign creditReturn = popNow;

    always_ff @(posedge ReadClock) begin
        if (recWrite) begin
            storage[wrPtr] <= recData;
        end
    end

    // Pointers wrap at the buffer depth
    always_ff @(posedge ReadClock) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
        end else begin
            if (recWrite) begin
                if (int'(wrPtr) == FifoDepth - 1) begin
                    wrPtr <= '0;
                end else begin
                    wrPtr <= wrPtr + 1'b1;
                end
            end
            if (popNow) begin
                if (int'(rdPtr) == FifoDepth - 1) begin
                    rdPtr <= '0;
                end else begin
                    rdPtr <= rdPtr + 1'b1;
                end
            end
        end
    end

    // Write while full cannot happen, the producer is out of credit by then
    always_ff @(posedge ReadClock) begin
        if (rst) begin
            occupancy <= '0;
        end else begin
            case ({recWrite, popNow})
                2'b10:   occupancy <= occupancy + 1'b1;
                2'b01:   occupancy <= occupancy - 1'b1;
                default: occupancy <= occupancy;
            endcase
        end
    end

endmodule

`default_nettype wire
